/* run_sim.sh */
#!/usr/bin/env bash
# Builds the victim cache testbench with Verilator and runs it.
# Exits with status 0 only when the run prints the pass message.

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

if ! verilator --binary --timing -j 0 \
	--top-module victim_cache_tb \
	-Mdir "$build_dir" \
	-f sources.f; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$("./$build_dir/Vvictim_cache_tb")
sim_status=$?
printf '%s\n' "$sim_output"

if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "STATUS: PASS"; then
	exit 0
fi

echo "Pass message not found in simulation output"
exit 1

/* sources.f */
src/vc_pkg.sv
src/vc_entry_if.sv
src/vc_front_end.sv
src/vc_entry.sv
src/vc_hit_select.sv
src/victim_cache.sv
verif/victim_cache_tb.sv

/* src/vc_entry.sv */
// One victim line with its tag, valid and dirty state.
// Compares its tag against the lookup tag and returns the selected word.
// A store that hits the line marks it dirty, and a dirty line reports no hit
// until a fill reuses the slot.

`timescale 1ns/1ns

module vc_entry
	import vc_pkg::*;
(
	input  logic       cache_clk,
	input  logic       rst_n,
	vc_entry_if.entry  ent
);

	// Line payload and tag.
	line_t   line_q;
	vc_tag_t tag_q;

	// Control state.
	logic valid_q;
	logic dirty_q;

	// Valid with an equal tag regardless of dirty.
	logic raw_match;

	// The line split into its words.
	word_t line_words [VC_LINE_WORDS];

	// A fill loads the payload and tag.
	always_ff @(posedge cache_clk)
	begin
		if (ent.fill_en)
		begin
			line_q <= ent.fill_line;
			tag_q  <= ent.fill_tag;
		end
	end

	// A fill makes the entry valid; there is no invalidate.
	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid_q <= 1'b0;
		end
		else if (ent.fill_en)
		begin
			valid_q <= 1'b1;
		end
	end

	// The fill takes priority, so a fill and a store hit at the
	// same edge leave the entry clean with the new line.
	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			dirty_q <= 1'b0;
		end
		else if (ent.fill_en)
		begin
			dirty_q <= 1'b0;
		end
		else if (raw_match && ent.store)
		begin
			dirty_q <= 1'b1;
		end
	end

	assign raw_match = valid_q && (tag_q == ent.look_tag);

	// A dirty copy is stale.
	assign ent.hit = raw_match && !dirty_q;

	// Word multiplexer with word 0 in the low bits.
	always_comb
	begin
		for (int w = 0; w < VC_LINE_WORDS; w++)
		begin
			line_words[w] = line_q[w*VC_WORD_W +: VC_WORD_W];
		end
	end

	assign ent.word = line_words[ent.word_sel];

endmodule

/* src/vc_entry_if.sv */
// Per-entry bundle between the front end, one victim entry and the hit selector.
// The top level keeps one instance per entry in an array indexed by entry number.

`timescale 1ns/1ns

interface vc_entry_if
	import vc_pkg::*;
();

	// Fill side, one-cycle strobe with the new line and tag.
	logic    fill_en;
	line_t   fill_line;
	vc_tag_t fill_tag;

	// Lookup side, the same on every entry.
	logic      store;
	vc_tag_t   look_tag;
	word_idx_t word_sel;

	// Entry result.
	logic  hit;
	word_t word;

	modport front (output fill_en, fill_line, fill_tag, look_tag, word_sel, store);

	modport entry (input fill_en, fill_line, fill_tag, look_tag, word_sel, store,
		output hit, word);

	modport sel (input hit, word);

endinterface

/* src/vc_front_end.sv */
// Front end of the victim cache.
// Splits the lookup address, broadcasts it with the store level, and steers
// each fill to the entry under the round-robin pointer.

`timescale 1ns/1ns

module vc_front_end
	import vc_pkg::*;
(
	input  logic           cache_clk,
	input  logic           rst_n,
	input  logic           fill,
	input  line_t          fill_line,
	input  vc_tag_t        fill_tag,
	input  addr_t          addr,
	input  logic           store,
	vc_entry_if.front      ent [VC_ENTRIES]
);

	// Slot that the next fill overwrites.
	entry_ptr_t fill_ptr;

	// One-hot fill strobe, at most one bit high.
	logic [VC_ENTRIES-1:0] fill_dec;

	// Address fields used by the lookup.
	vc_tag_t   look_tag;
	word_idx_t word_sel;

	// The byte offset plays no part in the lookup.
	assign look_tag = addr[VC_ADDR_W-1 -: VC_TAG_W];
	assign word_sel = addr[VC_BYTE_OFS +: VC_WORD_IDX_W];

	// Strict FIFO replacement, the pointer wraps from the last entry to 0.
	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			fill_ptr <= '0;
		end
		else if (fill)
		begin
			fill_ptr <= fill_ptr + entry_ptr_t'(1);
		end
	end

	// Decode the pointer into a strobe for the selected entry.
	always_comb
	begin
		fill_dec = '0;
		if (fill)
		begin
			fill_dec[fill_ptr] = 1'b1;
		end
	end

	// Fill data and lookup fields go to every entry.
	// only fill_en differs between them.
	for (genvar i = 0; i < VC_ENTRIES; i++)
	begin : g_drive
		assign ent[i].fill_en   = fill_dec[i];
		assign ent[i].fill_line = fill_line;
		assign ent[i].fill_tag  = fill_tag;
		assign ent[i].look_tag  = look_tag;
		assign ent[i].word_sel  = word_sel;
		assign ent[i].store     = store;
	end

endmodule

/* src/vc_hit_select.sv */
// Merges the per-entry results into the cache hit flag and output word.
// The lowest-numbered hitting entry wins, and the word is zero on a miss.

`timescale 1ns/1ns

module vc_hit_select
	import vc_pkg::*;
(
	vc_entry_if.sel  sel [VC_ENTRIES],
	output word_t    data_out,
	output logic     vc_hit
);

	// Entry results gathered into plain arrays.
	logic [VC_ENTRIES-1:0] hit_vec;
	word_t                 word_arr [VC_ENTRIES];

	for (genvar i = 0; i < VC_ENTRIES; i++)
	begin : g_gather
		assign hit_vec[i]  = sel[i].hit;
		assign word_arr[i] = sel[i].word;
	end

	assign vc_hit = |hit_vec;

	// Scan from the top down so the lowest hit is written last.
	// two clean matches only occur if a tag was filled twice.
	always_comb
	begin
		data_out = '0;
		for (int i = VC_ENTRIES - 1; i >= 0; i--)
		begin
			if (hit_vec[i])
			begin
				data_out = word_arr[i];
			end
		end
	end

endmodule

/* src/vc_pkg.sv */
// Geometry and width types of the victim cache.
// Import it wherever the address split, line layout or entry count is needed,
// in the RTL and in the testbench alike.

package vc_pkg;

	// Address and data widths.
	localparam int VC_ADDR_W = 32;
	localparam int VC_WORD_W = 32;

	// Words held by one victim line.
	localparam int VC_LINE_WORDS = 4;

	// Number of fully associative entries.
	localparam int VC_ENTRIES = 4;

	// Byte offset bits below the word index.
	localparam int VC_BYTE_OFS = 2;

	// Word index bits, derived from the line size.
	localparam int VC_WORD_IDX_W = $clog2(VC_LINE_WORDS);

	// The tag is everything above the word index.
	localparam int VC_TAG_W = VC_ADDR_W - VC_BYTE_OFS - VC_WORD_IDX_W;

	// Entry number width, used by the round-robin pointer.
	localparam int VC_PTR_W = $clog2(VC_ENTRIES);

	// Byte address.
	typedef logic [VC_ADDR_W-1:0] addr_t;

	// One data word.
	typedef logic [VC_WORD_W-1:0] word_t;

	// Whole line, word 0 in the least significant bits.
	typedef logic [VC_LINE_WORDS*VC_WORD_W-1:0] line_t;

	// Line tag.
	typedef logic [VC_TAG_W-1:0] vc_tag_t;

	// Word index inside a line.
	typedef logic [VC_WORD_IDX_W-1:0] word_idx_t;

	// Entry number.
	typedef logic [VC_PTR_W-1:0] entry_ptr_t;

endpackage

/* src/victim_cache.sv */
// Fully associative victim cache beside a first-level data cache.
// Evicted lines are filled whole in round-robin order, lookups are
// combinational, and a store that hits marks the line stale.

`timescale 1ns/1ns

module victim_cache
	import vc_pkg::*;
(
	input  logic    cache_clk,
	input  logic    rst_n,
	input  logic    fill,
	input  line_t   fill_line,
	input  vc_tag_t fill_tag,
	input  addr_t   addr,
	input  logic    store,
	output word_t   data_out,
	output logic    vc_hit
);

	// One bundle per entry.
	vc_entry_if ent_if [VC_ENTRIES] ();

	// Address split, broadcast and fill steering.
	vc_front_end vc_front_end_i
	(
		.cache_clk (cache_clk),
		.rst_n     (rst_n),
		.fill      (fill),
		.fill_line (fill_line),
		.fill_tag  (fill_tag),
		.addr      (addr),
		.store     (store),
		.ent       (ent_if)
	);

	// The victim entries.
	for (genvar i = 0; i < VC_ENTRIES; i++)
	begin : g_entry
		vc_entry vc_entry_i
		(
			.cache_clk (cache_clk),
			.rst_n     (rst_n),
			.ent       (ent_if[i])
		);
	end

	// Merge of hits and words.
	vc_hit_select vc_hit_select_i
	(
		.sel      (ent_if),
		.data_out (data_out),
		.vc_hit   (vc_hit)
	);

endmodule

/* verif/victim_cache_tb.sv */
// Self-checking testbench for the victim cache.
// A reference model follows the fill, store and lookup rules, and a compare
// process checks vc_hit and data_out against it just before every rising edge.

`timescale 1ns/1ns

module victim_cache_tb
	import vc_pkg::*;
();

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 4;
	localparam int RAND_SEED    = 99866;
	localparam int DIRECTED_OPS = 90;
	localparam int RAND_OPS     = 400;
	localparam int TIMEOUT_NS   = (RESET_CYCLES + DIRECTED_OPS + RAND_OPS) * CLK_PERIOD * 2;

	// DUT connections.
	logic    cache_clk;
	logic    rst_n;
	logic    fill;
	line_t   fill_line;
	vc_tag_t fill_tag;
	addr_t   addr;
	logic    store;
	word_t   data_out;
	logic    vc_hit;

	// Reference model state.
	word_t   ref_words [VC_ENTRIES][VC_LINE_WORDS];
	vc_tag_t ref_tag   [VC_ENTRIES];
	logic    ref_valid [VC_ENTRIES];
	logic    ref_dirty [VC_ENTRIES];
	int      ref_ptr;

	// Bookkeeping.
	string test_name;
	logic  checking;
	int    n_checks;
	int    n_errors;

	victim_cache victim_cache_i
	(
		.cache_clk (cache_clk),
		.rst_n     (rst_n),
		.fill      (fill),
		.fill_line (fill_line),
		.fill_tag  (fill_tag),
		.addr      (addr),
		.store     (store),
		.data_out  (data_out),
		.vc_hit    (vc_hit)
	);

	initial
	begin
		cache_clk = 1'b0;
		forever #(CLK_PERIOD / 2) cache_clk = ~cache_clk;
	end

	// Expected lookup result from the first clean valid entry with the same tag.
	function automatic logic ref_lookup(input addr_t a, output word_t w);
		vc_tag_t   t;
		word_idx_t idx;
		logic      found;
		t     = vc_tag_t'(a >> (VC_BYTE_OFS + VC_WORD_IDX_W));
		idx   = word_idx_t'(a >> VC_BYTE_OFS);
		found = 1'b0;
		w     = '0;
		for (int e = 0; e < VC_ENTRIES; e++)
		begin
			if (!found && ref_valid[e] && !ref_dirty[e] && ref_tag[e] == t)
			begin
				found = 1'b1;
				w     = ref_words[e][idx];
			end
		end
		return found;
	endfunction

	// The model applies stores before fills at each rising edge so that a fill wins.
	always @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int e = 0; e < VC_ENTRIES; e++)
			begin
				ref_valid[e] = 1'b0;
				ref_dirty[e] = 1'b0;
			end
			ref_ptr = 0;
		end
		else
		begin
			if (store)
			begin
				for (int e = 0; e < VC_ENTRIES; e++)
				begin
					if (ref_valid[e] &&
						ref_tag[e] == vc_tag_t'(addr >> (VC_BYTE_OFS + VC_WORD_IDX_W)))
					begin
						ref_dirty[e] = 1'b1;
					end
				end
			end
			if (fill)
			begin
				for (int w = 0; w < VC_LINE_WORDS; w++)
				begin
					ref_words[ref_ptr][w] = fill_line[w*VC_WORD_W +: VC_WORD_W];
				end
				ref_tag[ref_ptr]   = fill_tag;
				ref_valid[ref_ptr] = 1'b1;
				ref_dirty[ref_ptr] = 1'b0;
				ref_ptr            = (ref_ptr + 1) % VC_ENTRIES;
			end
		end
	end

	task automatic check_hit(input string name, input logic exp, input logic act);
		n_checks++;
		if (act !== exp)
		begin
			n_errors++;
			$display("[FAIL] %s: vc_hit expected %0b, actual %0b", name, exp, act);
		end
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		n_checks++;
		if (act !== exp)
		begin
			n_errors++;
			$display("[FAIL] %s: data_out expected %08h, actual %08h", name, exp, act);
		end
	endtask

	// Samples one time unit before each rising edge.
	initial
	begin
		logic  exp_hit;
		word_t exp_word;
		forever
		begin
			@(negedge cache_clk);
			#1;
			if (checking)
			begin
				exp_hit = ref_lookup(addr, exp_word);
				check_hit(test_name, exp_hit, vc_hit);
				check_word(test_name, exp_word, data_out);
			end
		end
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("Watchdog: the tests did not finish within %0d ns, run stopped.", TIMEOUT_NS);
		$display("STATUS: FAIL");
		$finish;
	end

	function automatic addr_t make_addr(input vc_tag_t t, input int w, input int b);
		return (addr_t'(t) << (VC_BYTE_OFS + VC_WORD_IDX_W)) |
			(addr_t'(w) << VC_BYTE_OFS) | addr_t'(b);
	endfunction

	function automatic line_t rand_line();
		line_t ln;
		for (int w = 0; w < VC_LINE_WORDS; w++)
		begin
			ln[w*VC_WORD_W +: VC_WORD_W] = word_t'($urandom);
		end
		return ln;
	endfunction

	// One clock cycle of stimulus applied on the falling edge.
	task automatic drive_cycle(input logic f, input line_t ln, input vc_tag_t tg,
		input addr_t a, input logic st);
		@(negedge cache_clk);
		fill      = f;
		fill_line = ln;
		fill_tag  = tg;
		addr      = a;
		store     = st;
	endtask

	task automatic lookup(input vc_tag_t tg, input int w);
		drive_cycle(1'b0, '0, '0, make_addr(tg, w, 0), 1'b0);
	endtask

	task automatic fill_entry(input vc_tag_t tg);
		drive_cycle(1'b1, rand_line(), tg, '0, 1'b0);
	endtask

	task automatic store_to(input vc_tag_t tg);
		drive_cycle(1'b0, '0, '0, make_addr(tg, 0, 0), 1'b1);
	endtask

	initial
	begin
		void'($urandom(RAND_SEED));
		rst_n     = 1'b0;
		fill      = 1'b0;
		fill_line = '0;
		fill_tag  = '0;
		addr      = '0;
		store     = 1'b0;
		checking  = 1'b0;
		n_checks  = 0;
		n_errors  = 0;
		test_name = "reset";
		repeat (RESET_CYCLES) @(posedge cache_clk);
		@(negedge cache_clk);
		rst_n    = 1'b1;
		checking = 1'b1;

		test_name = "miss after reset";
		repeat (16) drive_cycle(1'b0, '0, '0, addr_t'($urandom), 1'b0);

		test_name = "four fills";
		for (int e = 0; e < VC_ENTRIES; e++)
			fill_entry(vc_tag_t'(32'h100 + e));
		for (int e = 0; e < VC_ENTRIES; e++)
			for (int w = 0; w < VC_LINE_WORDS; w++)
				lookup(vc_tag_t'(32'h100 + e), w);

		// Slot 0 holds the oldest line.
		test_name = "round-robin eviction";
		fill_entry(vc_tag_t'(32'h104));
		for (int t = 0; t < 5; t++)
			for (int w = 0; w < VC_LINE_WORDS; w++)
				lookup(vc_tag_t'(32'h100 + t), w);

		test_name = "store marks dirty";
		store_to(vc_tag_t'(32'h102));
		lookup(vc_tag_t'(32'h102), 0);
		store_to(vc_tag_t'(32'h1ff));
		lookup(vc_tag_t'(32'h101), 1);
		lookup(vc_tag_t'(32'h103), 1);
		lookup(vc_tag_t'(32'h104), 1);
		// Pointer is at slot 1 and the dirty line sits in slot 2.
		fill_entry(vc_tag_t'(32'h105));
		fill_entry(vc_tag_t'(32'h106));
		for (int w = 0; w < VC_LINE_WORDS; w++)
			lookup(vc_tag_t'(32'h106), w);
		lookup(vc_tag_t'(32'h102), 0);

		// Slot 3 is under the pointer and holds tag 0x103.
		test_name = "fill beats store";
		drive_cycle(1'b1, rand_line(), vc_tag_t'(32'h107), make_addr(vc_tag_t'(32'h103), 2, 0),
			1'b1);
		for (int w = 0; w < VC_LINE_WORDS; w++)
			lookup(vc_tag_t'(32'h107), w);
		lookup(vc_tag_t'(32'h103), 0);

		// A small tag pool keeps hits and repeated tags frequent.
		test_name = "random mix";
		for (int n = 0; n < RAND_OPS; n++)
		begin
			drive_cycle(($urandom % 4) == 0, rand_line(), vc_tag_t'(32'h200 + ($urandom % 8)),
				make_addr(vc_tag_t'(32'h200 + ($urandom % 8)), int'($urandom % 4),
				int'($urandom % 4)), ($urandom % 5) == 0);
		end

		test_name = "idle";
		drive_cycle(1'b0, '0, '0, '0, 1'b0);
		@(posedge cache_clk);
		checking = 1'b0;

		$display("Checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
